// File: source/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Data path and address width
`define XLEN 32

// Architectural integer registers
`define NUM_REGS 32

`define RESET_PC 32'h0000_0000

`endif

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

    // Field layouts of the RV32I base formats, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, five views of it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // SUB and SRA

endpackage

// File: source/exec_pkg.sv
package exec_pkg;

    // One-hot ALU operation select
    typedef logic [9:0] alu_op_t;

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLL  = 2;
    localparam int ALU_SLT  = 3;
    localparam int ALU_SLTU = 4;
    localparam int ALU_XOR  = 5;
    localparam int ALU_SRL  = 6;
    localparam int ALU_SRA  = 7;
    localparam int ALU_OR   = 8;
    localparam int ALU_AND  = 9;

    // Branch condition is the branch funct3 as encoded
    typedef enum logic [2:0] {
        BR_EQ  = rv_isa_pkg::F3_BEQ,
        BR_NE  = rv_isa_pkg::F3_BNE,
        BR_LT  = rv_isa_pkg::F3_BLT,
        BR_GE  = rv_isa_pkg::F3_BGE,
        BR_LTU = rv_isa_pkg::F3_BLTU,
        BR_GEU = rv_isa_pkg::F3_BGEU
    } br_code_t;

endpackage

// File: source/inst_decode.sv
`include "exec_defines.svh"

module inst_decode import rv_isa_pkg::*, exec_pkg::*; (
    input  inst_u             inst,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic [4:0]        rd,
    output logic [`XLEN-1:0]  imm,
    output logic              use_imm,
    output logic              zero_op1,    // LUI adds to zero
    output logic              is_branch,
    output logic              is_jal,
    output logic              writes_rd,
    output logic              illegal,
    output alu_op_t           alu_op,
    output br_code_t          br_code
);

    logic [`XLEN-1:0] imm_i, imm_b, imm_u, imm_j;
    logic             f7_base, f7_alt;
    logic             is_op;

    // Sign-extended immediates, one per format
    assign imm_i = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
    assign imm_b = {{(`XLEN-13){inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.u.imm31_12, 12'h000};
    assign imm_j = {{(`XLEN-21){inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                    inst.j.imm11, inst.j.imm10_1, 1'b0};

    assign f7_base = inst.r.funct7 == F7_BASE;
    assign f7_alt  = inst.r.funct7 == F7_ALT;
    assign is_op   = inst.r.opcode == OPC_OP;

    // Register fields sit at the same place in every format that has them
    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;
    assign rd  = inst.r.rd;

    always_comb begin
        imm       = '0;
        use_imm   = 1'b0;
        zero_op1  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        writes_rd = 1'b0;
        illegal   = 1'b0;
        alu_op    = '0;
        br_code   = BR_EQ;
        case (inst.r.opcode)
            OPC_OP, OPC_OP_IMM: begin
                writes_rd = 1'b1;
                use_imm   = !is_op;
                imm       = imm_i;
                case (inst.r.funct3)
                    F3_ADD_SUB: begin
                        alu_op[ALU_ADD] = !(is_op && f7_alt);
                        alu_op[ALU_SUB] = is_op && f7_alt;
                        illegal         = is_op && !f7_base && !f7_alt;
                    end
                    F3_SLL: begin
                        alu_op[ALU_SLL] = 1'b1;
                        illegal         = !f7_base;    // SLLI checks imm[11:5] too
                    end
                    F3_SRL_SRA: begin
                        alu_op[ALU_SRL] = f7_base;
                        alu_op[ALU_SRA] = f7_alt;
                        illegal         = !f7_base && !f7_alt;
                    end
                    F3_SLT:  alu_op[ALU_SLT]  = 1'b1;
                    F3_SLTU: alu_op[ALU_SLTU] = 1'b1;
                    F3_XOR:  alu_op[ALU_XOR]  = 1'b1;
                    F3_OR:   alu_op[ALU_OR]   = 1'b1;
                    default: alu_op[ALU_AND]  = 1'b1;
                endcase
                if (is_op && !f7_base && !illegal && !alu_op[ALU_SUB] && !alu_op[ALU_SRA])
                    illegal = 1'b1;                    // Other R-type ops need funct7 zero
            end
            OPC_LUI: begin
                writes_rd       = 1'b1;
                use_imm         = 1'b1;
                zero_op1        = 1'b1;
                imm             = imm_u;
                alu_op[ALU_ADD] = 1'b1;
            end
            OPC_JAL: begin
                writes_rd = 1'b1;                      // Link value comes from pc+4
                is_jal    = 1'b1;
                imm       = imm_j;
            end
            OPC_BRANCH: begin
                is_branch       = 1'b1;
                imm             = imm_b;
                alu_op[ALU_SUB] = 1'b1;                // Compare via the adder
                case (inst.b.funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU:
                        br_code = br_code_t'(inst.b.funct3);
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            writes_rd = 1'b0;
            alu_op    = '0;
        end
    end

endmodule

// File: source/alu.sv
`include "exec_defines.svh"

module alu import exec_pkg::*; (
    input  logic [`XLEN-1:0] operand1,
    input  logic [`XLEN-1:0] operand2,
    input  alu_op_t          op,
    input  br_code_t         br_code,
    output logic [`XLEN-1:0] out,
    output logic             br_taken
);

    logic             invert;
    logic [`XLEN-1:0] adder_b;
    logic [`XLEN-1:0] adder_res;
    logic             adder_cout;
    logic             adder_zero;
    logic             lt_signed;
    logic [`XLEN-1:0] shift_res;
    logic             is_shift;

    // Subtract and both compares run through the one adder
    assign invert  = op[ALU_SUB] | op[ALU_SLT] | op[ALU_SLTU];
    assign adder_b = invert ? ~operand2 : operand2;
    assign {adder_cout, adder_res} = {1'b0, operand1} + {1'b0, adder_b}
                                     + {{`XLEN{1'b0}}, invert};

    assign adder_zero = ~|adder_res;
    // Signs differ: operand1 negative wins, else the difference sign decides
    assign lt_signed  = (operand1[`XLEN-1] & ~operand2[`XLEN-1])
                      | (~(operand1[`XLEN-1] ^ operand2[`XLEN-1]) & adder_res[`XLEN-1]);

    assign is_shift = op[ALU_SLL] | op[ALU_SRL] | op[ALU_SRA];

    always_comb begin
        if (op[ALU_SLL])
            shift_res = operand1 << operand2[4:0];
        else if (op[ALU_SRA])
            shift_res = $unsigned($signed(operand1) >>> operand2[4:0]);
        else
            shift_res = operand1 >> operand2[4:0];
    end

    // One-hot select, so an AND-OR tree is enough
    assign out = ({`XLEN{op[ALU_ADD] | op[ALU_SUB]}} & adder_res)
               | ({`XLEN{is_shift}}                 & shift_res)
               | ({`XLEN{op[ALU_SLT]}}              & {{(`XLEN-1){1'b0}}, lt_signed})
               | ({`XLEN{op[ALU_SLTU]}}             & {{(`XLEN-1){1'b0}}, ~adder_cout})
               | ({`XLEN{op[ALU_XOR]}}              & (operand1 ^ operand2))
               | ({`XLEN{op[ALU_OR]}}               & (operand1 | operand2))
               | ({`XLEN{op[ALU_AND]}}              & (operand1 & operand2));

    // Valid only when the subtract path is selected
    always_comb begin
        case (br_code)
            BR_EQ:   br_taken = adder_zero;
            BR_NE:   br_taken = !adder_zero;
            BR_LT:   br_taken = lt_signed;
            BR_GE:   br_taken = !lt_signed;
            BR_LTU:  br_taken = !adder_cout;   // Borrow out means below
            BR_GEU:  br_taken = adder_cout;
            default: br_taken = 1'b0;
        endcase
    end

endmodule

// File: source/reg_file.sv
`include "exec_defines.svh"

module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data,
    input  logic             we,
    input  logic [4:0]       wa,
    input  logic [`XLEN-1:0] wd
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;                // x0 is never written
        end
    end

    // Reads are combinational, a write shows up the cycle after
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    a_x0_stays_zero: assert property (
        @(posedge clk) disable iff (rst)
        (we && wa == 5'd0) |=> (regs[0] == '0)
    ) else $error("x0 changed after a write to address 0");

endmodule

// File: source/exec_core.sv
`include "exec_defines.svh"

module exec_core import exec_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid,
    input  logic [31:0]      inst,
    output logic [`XLEN-1:0] pc,
    output logic             retire,
    output logic             branch_taken,
    output logic             illegal,
    output logic [4:0]       wb_rd,
    output logic [`XLEN-1:0] wb_data
);

    logic [4:0]       rs1_idx, rs2_idx, rd_idx;
    logic [`XLEN-1:0] imm;
    logic             use_imm, zero_op1, is_branch, is_jal, writes_rd, dec_illegal;
    alu_op_t          alu_op;
    br_code_t         br_code;
    logic [`XLEN-1:0] rs1_data, rs2_data;
    logic [`XLEN-1:0] operand1, operand2, alu_out;
    logic             alu_br_taken;
    logic             take;
    logic [`XLEN-1:0] pc_plus4, target, rd_data;

    inst_decode u_decode (
        .inst(inst), .rs1(rs1_idx), .rs2(rs2_idx), .rd(rd_idx), .imm, .use_imm, .zero_op1,
        .is_branch, .is_jal, .writes_rd, .illegal(dec_illegal), .alu_op, .br_code
    );

    reg_file u_regs (
        .clk, .rst, .rs1(rs1_idx), .rs2(rs2_idx), .rs1_data, .rs2_data,
        .we(inst_valid && writes_rd), .wa(rd_idx), .wd(rd_data)
    );

    assign operand1 = zero_op1 ? '0 : rs1_data;
    assign operand2 = use_imm ? imm : rs2_data;

    alu u_alu (
        .operand1, .operand2, .op(alu_op), .br_code, .out(alu_out), .br_taken(alu_br_taken)
    );

    assign pc_plus4 = pc + `XLEN'd4;
    assign target   = pc + imm;                       // Same adder for branch and JAL
    assign take     = !dec_illegal && ((is_branch && alu_br_taken) || is_jal);
    assign rd_data  = is_jal ? pc_plus4 : alu_out;   // JAL links pc+4

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= `RESET_PC;
            retire       <= 1'b0;
            illegal      <= 1'b0;
            branch_taken <= 1'b0;
        end else begin
            retire       <= inst_valid && !dec_illegal;
            illegal      <= inst_valid && dec_illegal;
            branch_taken <= inst_valid && !dec_illegal && is_branch && alu_br_taken;
            if (inst_valid)
                pc <= take ? target : pc_plus4;     // Illegal falls through to pc+4
        end
    end

    // Writeback report, qualified by retire
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            wb_rd   <= writes_rd ? rd_idx : 5'd0;
            wb_data <= rd_data;
        end
    end

    a_alu_op_onehot: assert property (
        @(posedge clk) disable iff (rst)
        (inst_valid && !dec_illegal) |-> $onehot0(alu_op)
    ) else $error("Decoder selected more than one ALU operation");

    a_retire_xor_illegal: assert property (
        @(posedge clk) disable iff (rst)
        !(retire && illegal)
    ) else $error("retire and illegal raised together");

endmodule

// File: test/exec_tb.sv
`include "exec_defines.svh"

module exec_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 2000;
    // R-type funct7 and funct3 for add, sub, sll, slt, sltu, xor, srl, sra, or, and
    localparam logic [9:0] R_OPS [10] = '{{7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd1},
        {7'h00, 3'd2}, {7'h00, 3'd3}, {7'h00, 3'd4}, {7'h00, 3'd5}, {7'h20, 3'd5},
        {7'h00, 3'd6}, {7'h00, 3'd7}};
    localparam int PAIR_A [6] = '{1, 3, 4, 3, 1, 3};
    localparam int PAIR_B [6] = '{2, 4, 3, 5, 6, 7};
    localparam logic [2:0] BR_F3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    logic             clk, rst, inst_valid;
    logic [31:0]      inst;
    logic [`XLEN-1:0] pc, wb_data;
    logic             retire, branch_taken, illegal;
    logic [4:0]       wb_rd;

    logic [31:0] shadow [32];    // Reference register file
    logic [31:0] shadow_pc;
    logic [31:0] prog [$];       // Words of the next run
    integer      seed = 32'heaf3_7c6e;
    int          errors, test_errors, checks, tests, cycles;
    string       test_name;
    logic        p_ill, p_wr, p_taken;
    logic [4:0]  p_rd;
    logic [31:0] p_data;

    exec_core uut (.clk, .rst, .inst_valid, .inst, .pc, .retire, .branch_taken, .illegal,
                   .wb_rd, .wb_data);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_op(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // LUI then ADDI, upper part rounded for the sign of the low 12 bits
    task automatic load(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12;
        prog.push_back({upper[19:0], rd, 7'b0110111});
        prog.push_back(i_op(3'd0, rd, rd, v[11:0]));
    endtask

    task automatic cmp(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // ISA rules applied to the shadow state
    task automatic predict(input logic [31:0] w);
        logic [6:0]  opc, f7;
        logic [2:0]  f3;
        logic [31:0] a, b, op2, next_pc;
        logic        alt, is_r;
        opc = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        a = shadow[w[19:15]];
        b = shadow[w[24:20]];
        is_r = opc == 7'b0110011;
        alt = f7 == 7'h20;
        {p_ill, p_wr, p_taken} = 3'b000;
        p_data = '0;
        next_pc = shadow_pc + 32'd4;
        case (opc)
            7'b0110011, 7'b0010011: begin
                p_wr = 1'b1;
                op2 = is_r ? b : {{20{w[31]}}, w[31:20]};
                if (is_r)
                    p_ill = !(f7 == 7'h00 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
                else if (f3 == 3'd1)
                    p_ill = f7 != 7'h00;
                else if (f3 == 3'd5)
                    p_ill = !(f7 == 7'h00 || alt);
                case (f3)
                    3'd0: p_data = (alt && is_r) ? a - op2 : a + op2;
                    3'd1: p_data = a << op2[4:0];
                    3'd2: p_data = {31'b0, $signed(a) < $signed(op2)};
                    3'd3: p_data = {31'b0, a < op2};
                    3'd4: p_data = a ^ op2;
                    3'd5: p_data = alt ? $unsigned($signed(a) >>> op2[4:0]) : a >> op2[4:0];
                    3'd6: p_data = a | op2;
                    default: p_data = a & op2;
                endcase
            end
            7'b0110111: {p_wr, p_data} = {1'b1, w[31:12], 12'h000};
            7'b1101111: begin
                {p_wr, p_data} = {1'b1, shadow_pc + 32'd4};
                next_pc = shadow_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100011: begin
                case (f3)
                    3'd0: p_taken = a == b;
                    3'd1: p_taken = a != b;
                    3'd4: p_taken = $signed(a) < $signed(b);
                    3'd5: p_taken = $signed(a) >= $signed(b);
                    3'd6: p_taken = a < b;
                    3'd7: p_taken = a >= b;
                    default: p_ill = 1'b1;
                endcase
                if (p_taken)
                    next_pc = shadow_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            default: p_ill = 1'b1;
        endcase
        if (p_ill)
            p_wr = 1'b0;
        p_rd = p_wr ? w[11:7] : 5'd0;
        if (p_wr && w[11:7] != 5'd0)
            shadow[w[11:7]] = p_data;
        shadow_pc = next_pc;
    endtask

    // Issues the queued words on consecutive cycles, checks each one cycle later
    task automatic run();
        logic        e_ill [$], e_wr [$], e_taken [$];
        logic [4:0]  e_rd [$];
        logic [31:0] e_data [$], e_pc [$];
        int          n;
        n = prog.size();
        foreach (prog[k]) begin
            predict(prog[k]);
            e_ill.push_back(p_ill);
            e_wr.push_back(p_wr);
            e_taken.push_back(p_taken);
            e_rd.push_back(p_rd);
            e_data.push_back(p_data);
            e_pc.push_back(shadow_pc);
        end
        @(posedge clk);
        inst_valid <= 1'b1;
        inst <= prog[0];
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            if (k + 1 < n)
                inst <= prog[k+1];
            else
                inst_valid <= 1'b0;
            @(negedge clk);
            while (!(retire || illegal))
                @(negedge clk);
            cmp("illegal", e_ill[k], illegal);
            cmp("retire", !e_ill[k], retire);
            cmp("pc", e_pc[k], pc);
            if (!e_ill[k]) begin
                cmp("wb_rd", e_rd[k], wb_rd);
                cmp("branch_taken", e_taken[k], branch_taken);
                if (e_wr[k])
                    cmp("wb_data", e_data[k], wb_data);
            end
        end
        @(negedge clk);
        cmp("retire after run", 0, retire);     // Both are single-cycle pulses
        cmp("illegal after run", 0, illegal);
        prog.delete();
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
        tests++;
    endtask

    task automatic end_test();
        if (test_errors == 0)
            $display("%s: passed", test_name);
        else
            $display("%s: %0d errors", test_name, test_errors);
    endtask

    task automatic test_reset();
        begin_test("reset");
        repeat (4) begin
            @(negedge clk);
            cmp("pc", `RESET_PC, pc);
            cmp("retire", 0, retire);
            cmp("illegal", 0, illegal);
        end
        end_test();
    endtask

    task automatic test_r_ops();
        begin_test("r_type");
        load(5'd1, $random(seed));
        load(5'd2, $random(seed));
        load(5'd3, $random(seed) | 32'h8000_0000);
        load(5'd4, $random(seed) & 32'h7fff_ffff);
        load(5'd5, 32'hffff_ffff);                  // Shift amount 31
        load(5'd6, 32'h0000_0020);                  // Shift amount 32 wraps to 0
        load(5'd7, $random(seed) | 32'h8000_0000);
        run();
        for (int p = 0; p < 6; p++) begin
            for (int op = 0; op < 10; op++)
                prog.push_back(r_op(R_OPS[op][9:3], R_OPS[op][2:0], 5'(8 + op),
                                    5'(PAIR_A[p]), 5'(PAIR_B[p])));
            run();
        end
        end_test();
    endtask

    task automatic test_i_ops();
        logic [11:0] imm;
        logic [4:0]  sh;
        begin_test("i_type");
        for (int k = 0; k < 4; k++) begin
            imm = 12'($random(seed));
            sh = 5'($random(seed));
            prog.push_back(i_op(3'd0, 5'd18, 5'd1, imm));
            prog.push_back(i_op(3'd2, 5'd19, 5'd3, imm));
            prog.push_back(i_op(3'd3, 5'd20, 5'd3, imm));
            prog.push_back(i_op(3'd4, 5'd21, 5'd4, imm));
            prog.push_back(i_op(3'd6, 5'd22, 5'd1, imm));
            prog.push_back(i_op(3'd7, 5'd23, 5'd3, imm));
            prog.push_back(i_op(3'd1, 5'd24, 5'd1, {7'h00, sh}));
            prog.push_back(i_op(3'd5, 5'd25, 5'd3, {7'h00, sh}));
            prog.push_back(i_op(3'd5, 5'd26, 5'd3, {7'h20, sh}));
            run();
        end
        prog.push_back(i_op(3'd5, 5'd27, 5'd3, {7'h20, 5'd31}));
        prog.push_back(i_op(3'd1, 5'd28, 5'd1, {7'h00, 5'd31}));
        prog.push_back(i_op(3'd0, 5'd29, 5'd1, 12'h800));      // Most negative immediate
        prog.push_back(r_op(7'h00, 3'd0, 5'd30, 5'd29, 5'd29)); // Uses x29 from the cycle before
        prog.push_back(i_op(3'd4, 5'd31, 5'd30, 12'hfff));
        run();
        end_test();
    endtask

    task automatic test_branches();
        logic [31:0] v, u;
        begin_test("branch");
        v = $random(seed) | 32'h8000_0000;
        u = $random(seed);
        u = u >> 2;
        load(5'd10, v);
        load(5'd11, v);
        load(5'd12, u);
        load(5'd13, u + 32'd1);
        run();
        // Equal, signed less, unsigned less, greater
        for (int p = 0; p < 4; p++) begin
            for (int k = 0; k < 6; k++)
                prog.push_back(branch(BR_F3[k], (p == 2) ? 5'd12 : (p == 3) ? 5'd13 : 5'd10,
                                      (p == 0) ? 5'd11 : (p == 2) ? 5'd10 : 5'd12,
                                      13'($random(seed)) & 13'h1ffe));
            run();
        end
        end_test();
    endtask

    task automatic test_jal_x0();
        begin_test("jal_x0");
        prog.push_back(jal(5'd14, 21'($random(seed)) & 21'h0ffffe));
        prog.push_back(jal(5'd0, (21'($random(seed)) & 21'h1ffffe) | 21'h100000));
        prog.push_back(i_op(3'd0, 5'd0, 5'd1, 12'd123));
        prog.push_back({20'($random(seed)), 5'd0, 7'b0110111});
        prog.push_back(r_op(7'h00, 3'd0, 5'd15, 5'd0, 5'd0));
        prog.push_back(r_op(7'h00, 3'd0, 5'd16, 5'd14, 5'd0));
        run();
        end_test();
    endtask

    task automatic test_illegal();
        begin_test("illegal");
        prog.push_back({25'($random(seed)), 7'b0000011});       // Load opcode
        prog.push_back(r_op(7'h01, 3'd0, 5'd9, 5'd1, 5'd2));
        prog.push_back(i_op(3'd1, 5'd9, 5'd1, {7'h20, 5'd3}));
        prog.push_back(branch(3'd2, 5'd0, 5'd0, 13'h0040));     // Undefined funct3, equal operands
        run();
        for (int r = 1; r < 32; r++)
            prog.push_back(r_op(7'h00, 3'd0, 5'(r), 5'(r), 5'd0)); // Read back every register
        run();
        end_test();
    endtask

    initial begin
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        shadow_pc = `RESET_PC;
        foreach (shadow[i])
            shadow[i] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_r_ops();
        test_i_ops();
        test_branches();
        test_jal_x0();
        test_illegal();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: all.f
+incdir+source
source/rv_isa_pkg.sv
source/exec_pkg.sv
source/inst_decode.sv
source/alu.sv
source/reg_file.sv
source/exec_core.sv
test/exec_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= exec_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
